/* aes128_pipe.f */
rtl/aes_pkg.sv
rtl/sbox_pkg.sv
rtl/aes_sub_word.sv
rtl/aes_tbox_word.sv
rtl/aes_key_step.sv
rtl/aes_round.sv
rtl/aes_final_round.sv
rtl/aes128_pipe.sv
testbench/tb_aes128_pipe.sv

/* testbench/tb_aes128_pipe.sv */
/*
 Testbench for aes128_pipe: known-answer vectors, streaming, per-block keys
 and random repeat checks. Results are checked exactly 21 cycles after drive.
*/
`timescale 1ns/1ps

module tb_aes128_pipe;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_VEC      = 5;
    localparam int NUM_RANDOM   = 40;
    localparam int MAX_GAP      = 30;
    localparam int LATENCY      = aes_pkg::PIPE_LATENCY;

    // worst case length of all test phases, plus drain and margin
    localparam int RUN_CYCLES = RESET_CYCLES + NUM_VEC * (1 + LATENCY) + 2 * NUM_VEC +
                                NUM_RANDOM * (2 + MAX_GAP) + LATENCY + 1;
    localparam int WATCHDOG_CYCLES = RUN_CYCLES + LATENCY + 50;

    // what to do with the output when an entry falls due
    localparam int CHK_NONE   = 0;
    localparam int CHK_VALUE  = 1;
    localparam int CHK_RECORD = 2;
    localparam int CHK_SAME   = 3;

    logic            clk;
    logic            rst_n;
    aes_pkg::block_t plaintext;
    aes_pkg::block_t key;
    aes_pkg::block_t ciphertext;

    aes_pkg::block_t vec_key [NUM_VEC];
    aes_pkg::block_t vec_pt  [NUM_VEC];
    aes_pkg::block_t vec_ct  [NUM_VEC];
    // key changes on every cycle in this order
    int              key_order [NUM_VEC] = '{1, 0, 3, 2, 4};

    // pending checks, oldest first
    int              due_q  [$];
    int              mode_q [$];
    int              slot_q [$];
    aes_pkg::block_t exp_q  [$];
    aes_pkg::block_t rec_val [NUM_RANDOM];

    int              cycle;
    int              check_count;
    int              error_count;
    logic [31:0]     lcg_state;

    aes128_pipe i_aes128_pipe (
        .clk        (clk),
        .rst_n      (rst_n),
        .plaintext  (plaintext),
        .key        (key),
        .ciphertext (ciphertext)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("TIMEOUT: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("checks %0d, errors %0d", check_count, error_count + 1);
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic rand_block(output aes_pkg::block_t b);
        for (int w = 0; w < 4; w++)
        begin
            lcg_state = lcg_next(lcg_state);
            b[127 - 32 * w -: 32] = lcg_state;
        end
    endtask

    task automatic check_value(input string name, input aes_pkg::block_t actual,
                               input aes_pkg::block_t expected);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("MISMATCH %s: got %h, expected %h (cycle %0d)",
                     name, actual, expected, cycle);
        end
    endtask

    // FIPS-197 and SP 800-38A known answers
    task automatic load_table();
        vec_key[0] = 128'h000102030405060708090a0b0c0d0e0f;
        vec_pt[0]  = 128'h00112233445566778899aabbccddeeff;
        vec_ct[0]  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
        vec_key[1] = 128'h2b7e151628aed2a6abf7158809cf4f3c;
        vec_pt[1]  = 128'h3243f6a8885a308d313198a2e0370734;
        vec_ct[1]  = 128'h3925841d02dc09fbdc118597196a0b32;
        vec_key[2] = 128'h0;
        vec_pt[2]  = 128'h0;
        vec_ct[2]  = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
        vec_key[3] = 128'h2b7e151628aed2a6abf7158809cf4f3c;
        vec_pt[3]  = 128'h6bc1bee22e409f96e93d7e117393172a;
        vec_ct[3]  = 128'h3ad77bb40d7a3660a89ecaf32466ef97;
        vec_key[4] = 128'h2b7e151628aed2a6abf7158809cf4f3c;
        vec_pt[4]  = 128'hae2d8a571e03ac9c9eb76fac45af8e51;
        vec_ct[4]  = 128'hf5d3d58503b9699de785895a96fdbaaf;
    endtask

    // one clock cycle: check what falls due, then drive the next inputs
    task automatic apply_cycle(input aes_pkg::block_t k, input aes_pkg::block_t p,
                               input int mode, input aes_pkg::block_t expected,
                               input int slot);
        @(posedge clk);
        #2;
        cycle++;
        while (due_q.size() > 0 && due_q[0] == cycle)
        begin
            if (mode_q[0] == CHK_VALUE)
                check_value("ciphertext", ciphertext, exp_q[0]);
            else if (mode_q[0] == CHK_RECORD)
                rec_val[slot_q[0]] = ciphertext;
            else
                check_value("ciphertext", ciphertext, rec_val[slot_q[0]]);
            void'(due_q.pop_front());
            void'(mode_q.pop_front());
            void'(slot_q.pop_front());
            void'(exp_q.pop_front());
        end
        key       = k;
        plaintext = p;
        if (mode != CHK_NONE)
        begin
            due_q.push_back(cycle + LATENCY);
            mode_q.push_back(mode);
            slot_q.push_back(slot);
            exp_q.push_back(expected);
        end
    endtask

    initial
    begin
        aes_pkg::block_t rk;
        aes_pkg::block_t rp;
        aes_pkg::block_t gk;
        aes_pkg::block_t gp;
        int              gap;

        rst_n       = 1'b0;
        key         = '0;
        plaintext   = '0;
        cycle       = 0;
        check_count = 0;
        error_count = 0;
        lcg_state   = 32'h813e_81a3;
        load_table();

        // reset holds the output at zero whatever the inputs do
        repeat (RESET_CYCLES)
        begin
            @(posedge clk);
            #2;
            check_value("ciphertext", ciphertext, '0);
            rand_block(gk);
            rand_block(gp);
            key       = gk;
            plaintext = gp;
        end
        rst_n     = 1'b1;
        key       = '0;
        plaintext = '0;

        // single blocks with idle zero inputs around them
        for (int r = 0; r < NUM_VEC; r++)
        begin
            apply_cycle(vec_key[r], vec_pt[r], CHK_VALUE, vec_ct[r], 0);
            repeat (LATENCY)
                apply_cycle('0, '0, CHK_NONE, '0, 0);
        end

        // back to back, then with the key changing every cycle
        for (int r = 0; r < NUM_VEC; r++)
            apply_cycle(vec_key[r], vec_pt[r], CHK_VALUE, vec_ct[r], 0);
        for (int r = 0; r < NUM_VEC; r++)
            apply_cycle(vec_key[key_order[r]], vec_pt[key_order[r]], CHK_VALUE,
                        vec_ct[key_order[r]], 0);

        // random pair applied twice with random traffic in between
        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            rand_block(rk);
            rand_block(rp);
            apply_cycle(rk, rp, CHK_RECORD, '0, n);
            lcg_state = lcg_next(lcg_state);
            gap = lcg_state[31:16] % (MAX_GAP + 1);
            repeat (gap)
            begin
                rand_block(gk);
                rand_block(gp);
                apply_cycle(gk, gp, CHK_NONE, '0, 0);
            end
            apply_cycle(rk, rp, CHK_SAME, '0, n);
        end

        // drain the pipeline
        repeat (LATENCY + 1)
            apply_cycle('0, '0, CHK_NONE, '0, 0);

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* rtl/aes128_pipe.sv */
/*
 Fully pipelined AES-128 encryptor, new block and key every cycle, no strobe.
 Ciphertext appears PIPE_LATENCY (21) cycles after the inputs are sampled.
*/
`timescale 1ns/1ps

module aes128_pipe (
    input  logic           clk,
    input  logic           rst_n,
    input  aes_pkg::block_t plaintext,
    input  aes_pkg::block_t key,
    output aes_pkg::block_t ciphertext
);

    // state_chain[i] and key_chain[i] enter round i together
    aes_pkg::block_t state_chain [aes_pkg::NUM_ROUNDS];
    aes_pkg::block_t key_chain   [aes_pkg::NUM_ROUNDS];
    aes_pkg::block_t round_key   [aes_pkg::NUM_ROUNDS];

    // initial AddRoundKey, key kept beside its block
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_chain[0] <= '0;
            key_chain[0]   <= '0;
        end
        else
        begin
            state_chain[0] <= plaintext ^ key;
            key_chain[0]   <= key;
        end
    end

    for (genvar i = 0; i < aes_pkg::NUM_ROUNDS; i++)
    begin : g_round
        if (i < aes_pkg::NUM_ROUNDS - 1)
        begin : g_full
            aes_key_step #(
                .RCON (aes_pkg::rcon(i + 1))
            ) i_key_step (
                .clk       (clk),
                .rst_n     (rst_n),
                .key_in    (key_chain[i]),
                .round_key (round_key[i]),
                .next_key  (key_chain[i + 1])
            );

            aes_round i_round (
                .clk       (clk),
                .rst_n     (rst_n),
                .state_in  (state_chain[i]),
                .round_key (round_key[i]),
                .state_out (state_chain[i + 1])
            );
        end
        else
        begin : g_last
            // no further key needed after the tenth step
            aes_key_step #(
                .RCON (aes_pkg::rcon(i + 1))
            ) i_key_step (
                .clk       (clk),
                .rst_n     (rst_n),
                .key_in    (key_chain[i]),
                .round_key (round_key[i]),
                .next_key  ()
            );

            aes_final_round i_final_round (
                .clk       (clk),
                .rst_n     (rst_n),
                .state_in  (state_chain[i]),
                .round_key (round_key[i]),
                .state_out (ciphertext)
            );
        end
    end

endmodule

/* rtl/aes_final_round.sv */
/*
 Last cipher round, no MixColumns, two cycles. round_key is used one
 cycle after state_in.
*/
`timescale 1ns/1ps

module aes_final_round (
    input  logic           clk,
    input  logic           rst_n,
    input  aes_pkg::block_t state_in,
    input  aes_pkg::block_t round_key,
    output aes_pkg::block_t state_out
);

    aes_pkg::byte_t [0:3] sub_col [4];
    aes_pkg::word_t       new_col [4];

    for (genvar c = 0; c < 4; c++)
    begin : g_col
        aes_sub_word i_sub_word (
            .clk      (clk),
            .rst_n    (rst_n),
            .word_in  (state_in[127 - 32 * c -: 32]),
            .word_out (sub_col[c])
        );
    end

    // reassemble in ShiftRows order and add the last key
    always_comb
    begin
        for (int j = 0; j < 4; j++)
        begin
            new_col[j] = {sub_col[j][0], sub_col[(j + 1) % 4][1],
                          sub_col[(j + 2) % 4][2], sub_col[(j + 3) % 4][3]} ^
                         round_key[127 - 32 * j -: 32];
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state_out <= '0;
        else
            state_out <= {new_col[0], new_col[1], new_col[2], new_col[3]};
    end

endmodule

/* rtl/aes_round.sv */
/*
 Full cipher round over two cycles. round_key must be valid one cycle
 after state_in, when the T-table register output is ready.
*/
`timescale 1ns/1ps

module aes_round (
    input  logic           clk,
    input  logic           rst_n,
    input  aes_pkg::block_t state_in,
    input  aes_pkg::block_t round_key,
    output aes_pkg::block_t state_out
);

    aes_pkg::word_t t_lane [4][4];
    aes_pkg::word_t new_col [4];

    // one lookup per column, lanes indexed [column][byte]
    for (genvar c = 0; c < 4; c++)
    begin : g_col
        aes_tbox_word i_tbox_word (
            .clk    (clk),
            .rst_n  (rst_n),
            .col_in (state_in[127 - 32 * c -: 32]),
            .t0     (t_lane[c][0]),
            .t1     (t_lane[c][1]),
            .t2     (t_lane[c][2]),
            .t3     (t_lane[c][3])
        );
    end

    // ShiftRows picks byte r of column j+r
    always_comb
    begin
        for (int j = 0; j < 4; j++)
        begin
            new_col[j] = t_lane[j][0] ^ t_lane[(j + 1) % 4][1] ^
                         t_lane[(j + 2) % 4][2] ^ t_lane[(j + 3) % 4][3] ^
                         round_key[127 - 32 * j -: 32];
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state_out <= '0;
        else
            state_out <= {new_col[0], new_col[1], new_col[2], new_col[3]};
    end

endmodule

/* rtl/aes_key_step.sv */
/*
 One AES-128 key-expansion round. round_key is valid one cycle after key_in
 and is combinational from registers; next_key follows one cycle later.
*/
`timescale 1ns/1ps

module aes_key_step #(
    parameter aes_pkg::byte_t RCON = 8'h01
) (
    input  logic           clk,
    input  logic           rst_n,
    input  aes_pkg::block_t key_in,
    output aes_pkg::block_t round_key,
    output aes_pkg::block_t next_key
);

    aes_pkg::word_t k0;
    aes_pkg::word_t k1;
    aes_pkg::word_t k2;
    aes_pkg::word_t k3;
    aes_pkg::word_t v0;
    aes_pkg::word_t v1;
    aes_pkg::word_t v2;
    aes_pkg::word_t v3;
    aes_pkg::word_t v0_q;
    aes_pkg::word_t v1_q;
    aes_pkg::word_t v2_q;
    aes_pkg::word_t v3_q;
    aes_pkg::word_t sub_w;

    assign {k0, k1, k2, k3} = key_in;

    // prefix XOR, rcon folded into the first word
    assign v0 = k0 ^ {RCON, 24'h0};
    assign v1 = v0 ^ k1;
    assign v2 = v1 ^ k2;
    assign v3 = v2 ^ k3;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            {v0_q, v1_q, v2_q, v3_q} <= '0;
        end
        else
        begin
            {v0_q, v1_q, v2_q, v3_q} <= {v0, v1, v2, v3};
        end
    end

    // SubWord(RotWord(w3)), aligned with the prefix register
    aes_sub_word i_sub_word (
        .clk      (clk),
        .rst_n    (rst_n),
        .word_in  ({k3[23:0], k3[31:24]}),
        .word_out (sub_w)
    );

    assign round_key = {v0_q ^ sub_w, v1_q ^ sub_w, v2_q ^ sub_w, v3_q ^ sub_w};

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            next_key <= '0;
        else
            next_key <= round_key;
    end

endmodule

/* rtl/aes_tbox_word.sv */
/*
 T-table lookup for one state column, one cycle of latency.
 t_k is the MixColumns contribution of byte k, already rotated into its lane.
*/
`timescale 1ns/1ps

module aes_tbox_word (
    input  logic          clk,
    input  logic          rst_n,
    input  aes_pkg::word_t col_in,
    output aes_pkg::word_t t0,
    output aes_pkg::word_t t1,
    output aes_pkg::word_t t2,
    output aes_pkg::word_t t3
);

    aes_pkg::byte_t [0:3] col_bytes;
    aes_pkg::byte_t [0:3] s_q;
    aes_pkg::byte_t [0:3] s2_q;
    aes_pkg::word_t       t_word [4];

    assign col_bytes = col_in;

    // s and 2s are registered, 3s is formed after the register
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            s_q  <= '0;
            s2_q <= '0;
        end
        else
        begin
            for (int k = 0; k < 4; k++)
            begin
                s_q[k]  <= sbox_pkg::sbox(col_bytes[k]);
                s2_q[k] <= sbox_pkg::xtime(sbox_pkg::sbox(col_bytes[k]));
            end
        end
    end

    // column {2s, s, s, 3s} of the MixColumns matrix
    always_comb
    begin
        for (int k = 0; k < 4; k++)
        begin
            t_word[k] = {s2_q[k], s_q[k], s_q[k], s_q[k] ^ s2_q[k]};
        end
    end

    // rotate right by the byte position
    assign t0 = t_word[0];
    assign t1 = {t_word[1][7:0],  t_word[1][31:8]};
    assign t2 = {t_word[2][15:0], t_word[2][31:16]};
    assign t3 = {t_word[3][23:0], t_word[3][31:24]};

endmodule

/* rtl/aes_sub_word.sv */
/*
 Registered SubWord, one cycle from word_in to word_out.
*/
`timescale 1ns/1ps

module aes_sub_word (
    input  logic          clk,
    input  logic          rst_n,
    input  aes_pkg::word_t word_in,
    output aes_pkg::word_t word_out
);

    // each byte goes through the table on its own lane
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            word_out <= '0;
        end
        else
        begin
            word_out <= {sbox_pkg::sbox(word_in[31:24]),
                         sbox_pkg::sbox(word_in[23:16]),
                         sbox_pkg::sbox(word_in[15:8]),
                         sbox_pkg::sbox(word_in[7:0])};
        end
    end

endmodule

/* rtl/sbox_pkg.sv */
/*
 Forward AES S-box only, no inverse table.
 xtime reduces with the AES polynomial x^8 + x^4 + x^3 + x + 1.
*/
package sbox_pkg;

    // entry 0 in the leftmost byte, one row of 16 per line
    localparam logic [0:255][7:0] SBOX_TABLE = {
        128'h637c777b_f26b6fc5_3001672b_fed7ab76,
        128'hca82c97d_fa5947f0_add4a2af_9ca472c0,
        128'hb7fd9326_363ff7cc_34a5e5f1_71d83115,
        128'h04c723c3_1896059a_071280e2_eb27b275,
        128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84,
        128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf,
        128'hd0efaafb_434d3385_45f9027f_503c9fa8,
        128'h51a3408f_929d38f5_bcb6da21_10fff3d2,
        128'hcd0c13ec_5f974417_c4a77e3d_645d1973,
        128'h60814fdc_222a9088_46eeb814_de5e0bdb,
        128'he0323a0a_4906245c_c2d3ac62_9195e479,
        128'he7c8376d_8dd54ea9_6c56f4ea_657aae08,
        128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a,
        128'h703eb566_4803f60e_613557b9_86c11d9e,
        128'he1f89811_69d98e94_9b1e87e9_ce5528df,
        128'h8ca1890d_bfe64268_41992d0f_b054bb16
    };

    function automatic aes_pkg::byte_t sbox(input aes_pkg::byte_t b);
        return SBOX_TABLE[b];
    endfunction

    // multiply by x in GF(2^8)
    function automatic aes_pkg::byte_t xtime(input aes_pkg::byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

endpackage

/* rtl/aes_pkg.sv */
/*
 AES-128 only: fixed 128-bit block and key, ten rounds.
 Blocks and words are big-endian, so word 0 and byte 0 sit in the top bits.
*/
package aes_pkg;

    typedef logic [7:0]   byte_t;
    typedef logic [31:0]  word_t;
    typedef logic [127:0] block_t;

    localparam int NUM_ROUNDS = 10;

    // input key-add register plus two registers per round
    localparam int PIPE_LATENCY = 1 + 2 * NUM_ROUNDS;

    // round constant for key expansion, rounds 1 to 10
    function automatic byte_t rcon(input int round_idx);
        byte_t rc;
        case (round_idx)
            1:       rc = 8'h01;
            2:       rc = 8'h02;
            3:       rc = 8'h04;
            4:       rc = 8'h08;
            5:       rc = 8'h10;
            6:       rc = 8'h20;
            7:       rc = 8'h40;
            8:       rc = 8'h80;
            9:       rc = 8'h1b;
            10:      rc = 8'h36;
            default: rc = 8'h00;
        endcase
        return rc;
    endfunction

endpackage
